//--- hw/gamePkg.sv
package gamePkg;

    // Screen coordinate, wide enough for the 320 by 240 playfield
    typedef logic [8:0] coordT;

    // Facing direction, the code picks the frame block in the sprite ROM
    typedef enum logic [1:0] {
        dirDown  = 2'd0,
        dirLeft  = 2'd1,
        dirUp    = 2'd2,
        dirRight = 2'd3
    } dirT;

    // Walk animation step, wraps every four pixel steps
    typedef logic [1:0] stepT;

    // Sprite ROM address
    // Twelve frames of 26 by 26 pixels need 8112 words
    typedef logic [12:0] spriteAddrT;

    // Animation frames stored per facing direction
    localparam int FRAMES_PER_DIR = 3;

endpackage

//--- hw/enemyStateIf.sv
`timescale 1ns/100ps

// Enemy state from the chaser to the sprite locator
interface enemyStateIf import gamePkg::*; ();

    coordT xPos;   // Left edge of the enemy box
    coordT yPos;   // Top edge of the enemy box
    dirT   dir;    // Facing direction
    stepT  step;   // Walk animation step

    modport chaser (
        output xPos,
        output yPos,
        output dir,
        output step
    );

    modport locator (
        input xPos,
        input yPos,
        input dir,
        input step
    );

endinterface

//--- hw/frameTick.sv
`timescale 1ns/100ps

module frameTick #(
    parameter int tickDivide = 4          // Frame edges per move
) (
    input  logic Clk,
    input  logic rst,
    input  logic frameClk,               // Slow frame clock, about 60 Hz
    output logic moveTick
);

    localparam int cntW = (tickDivide > 1) ? $clog2(tickDivide) : 1;

    logic            frameQ;              // Sampled frame clock
    logic            frameQd;             // Previous sample
    logic            edgePulse;           // One cycle per frame clock rise
    logic [cntW-1:0] edgeCount;
    logic            countWrap;

    assign countWrap = (edgeCount == cntW'(tickDivide - 1));

    always_ff @(posedge Clk) begin
        if (rst) begin
            frameQ    <= 1'b0;
            frameQd   <= 1'b0;
            edgePulse <= 1'b0;
            edgeCount <= '0;
        end else begin
            frameQ    <= frameClk;
            frameQd   <= frameQ;
            edgePulse <= frameQ && !frameQd;   // Rise seen on the sampled copy
            if (edgePulse) begin
                edgeCount <= countWrap ? '0 : edgeCount + 1'b1;
            end
        end
    end

    // Tick fires together with the last edge pulse of each group
    assign moveTick = edgePulse && countWrap;

endmodule

//--- hw/enemyChaser.sv
`timescale 1ns/100ps

module enemyChaser import gamePkg::*; #(
    parameter int objWidth  = 26,
    parameter int objHeight = 26,
    parameter int startX    = 100,        // Centre of the enemy at reset
    parameter int startY    = 60,
    parameter int xMin      = 0,
    parameter int xMax      = 319,
    parameter int yMin      = 0,
    parameter int yMax      = 239
) (
    input  logic        Clk,
    input  logic        rst,
    input  logic        moveTick,
    input  coordT       playerX,
    input  coordT       playerY,
    enemyStateIf.chaser state
);

    // Top left corner at reset
    localparam coordT resetX = coordT'(startX - objWidth / 2);
    localparam coordT resetY = coordT'(startY - objHeight / 2);

    // Last left edge and top edge before the box would meet the far bound
    localparam coordT xStopR = coordT'(xMax - objWidth);
    localparam coordT yStopB = coordT'(yMax - objHeight);
    localparam coordT xStopL = coordT'(xMin);
    localparam coordT yStopT = coordT'(yMin);

    coordT xPos, yPos;
    dirT   dir;
    stepT  step;

    coordT nextX, nextY;
    dirT   nextDir;
    logic  stepTaken;    // A pixel step happens on this tick

    // Horizontal first, then vertical
    always_comb begin
        nextX     = xPos;
        nextY     = yPos;
        nextDir   = dir;      // Held when level on both axes
        stepTaken = 1'b0;

        if (xPos < playerX) begin
            nextDir = dirRight;
            if (xPos < xStopR) begin
                nextX     = xPos + 1'b1;
                stepTaken = 1'b1;
            end
        end else if (xPos > playerX) begin
            nextDir = dirLeft;
            if (xPos > xStopL) begin
                nextX     = xPos - 1'b1;
                stepTaken = 1'b1;
            end
        end else if (yPos < playerY) begin
            nextDir = dirDown;
            if (yPos < yStopB) begin
                nextY     = yPos + 1'b1;
                stepTaken = 1'b1;
            end
        end else if (yPos > playerY) begin
            nextDir = dirUp;
            if (yPos > yStopT) begin
                nextY     = yPos - 1'b1;
                stepTaken = 1'b1;
            end
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            xPos <= resetX;
            yPos <= resetY;
            dir  <= dirDown;
            step <= '0;
        end else if (moveTick) begin
            xPos <= nextX;
            yPos <= nextY;
            dir  <= nextDir;
            if (stepTaken) begin
                step <= step + 1'b1;   // Animation only follows real movement
            end
        end
    end

    assign state.xPos = xPos;
    assign state.yPos = yPos;
    assign state.dir  = dir;
    assign state.step = step;

endmodule

//--- hw/spriteLocator.sv
`timescale 1ns/100ps

module spriteLocator import gamePkg::*; #(
    parameter int objWidth  = 26,
    parameter int objHeight = 26
) (
    input  logic         Clk,
    input  logic         rst,
    input  logic         pixReq,
    input  coordT        pixX,
    input  coordT        pixY,
    output logic         pixAck,
    output logic         isObj,
    output spriteAddrT   objAddress,
    enemyStateIf.locator state
);

    typedef enum logic {
        hsIdle,     // Waiting for a request
        hsAck       // Answer held until the request drops
    } hsStateT;

    hsStateT hsState;

    coordT      offX, offY;     // Pixel offset from the box corner
    logic       inBox;
    logic [3:0] frameIdx;       // 0 to 11
    spriteAddrT addrCalc;

    assign offX = pixX - state.xPos;
    assign offY = pixY - state.yPos;

    // Offsets wrap when the pixel is above or left of the box
    assign inBox = (pixX >= state.xPos) && (offX < coordT'(objWidth)) &&
                   (pixY >= state.yPos) && (offY < coordT'(objHeight));

    // Odd steps use the two walking frames, even steps the standing one
    always_comb begin
        frameIdx = 4'(FRAMES_PER_DIR * int'(state.dir));
        if (state.step[0]) begin
            frameIdx = frameIdx + 4'd1 + 4'(state.step[1]);
        end
    end

    always_comb begin
        addrCalc = '0;
        if (inBox) begin
            addrCalc = spriteAddrT'(offX) +
                       spriteAddrT'(offY) * spriteAddrT'(objWidth) +
                       spriteAddrT'(objWidth * objHeight) * spriteAddrT'(frameIdx);
        end
    end

    always_ff @(posedge Clk) begin
        if (rst) begin
            hsState <= hsIdle;
        end else begin
            case (hsState)
                hsIdle: if (pixReq) hsState <= hsAck;
                hsAck:  if (!pixReq) hsState <= hsIdle;
                default: hsState <= hsIdle;
            endcase
        end
    end

    // Answer captured only when a request is accepted
    always_ff @(posedge Clk) begin
        if (hsState == hsIdle && pixReq) begin
            isObj      <= inBox;
            objAddress <= addrCalc;
        end
    end

    assign pixAck = (hsState == hsAck);

endmodule

//--- hw/enemyTop.sv
`timescale 1ns/100ps

module enemyTop import gamePkg::*; #(
    parameter int objWidth   = 26,
    parameter int objHeight  = 26,
    parameter int startX     = 100,
    parameter int startY     = 60,
    parameter int xMin       = 0,       // Playfield bounds
    parameter int xMax       = 319,
    parameter int yMin       = 0,
    parameter int yMax       = 239,
    parameter int tickDivide = 4        // One pixel step per four frames
) (
    input  logic       Clk,
    input  logic       rst,
    input  logic       frameClk,
    input  coordT      playerX,
    input  coordT      playerY,
    input  logic       pixReq,
    input  coordT      pixX,
    input  coordT      pixY,
    output logic       pixAck,
    output logic       isObj,
    output spriteAddrT objAddress
);

    logic        moveTick;
    enemyStateIf enemyState ();

    frameTick #(
        .tickDivide (tickDivide)
    ) u_frameTick (
        .Clk      (Clk),
        .rst      (rst),
        .frameClk (frameClk),
        .moveTick (moveTick)
    );

    enemyChaser #(
        .objWidth  (objWidth),
        .objHeight (objHeight),
        .startX    (startX),
        .startY    (startY),
        .xMin      (xMin),
        .xMax      (xMax),
        .yMin      (yMin),
        .yMax      (yMax)
    ) u_enemyChaser (
        .Clk      (Clk),
        .rst      (rst),
        .moveTick (moveTick),
        .playerX  (playerX),
        .playerY  (playerY),
        .state    (enemyState.chaser)
    );

    spriteLocator #(
        .objWidth  (objWidth),
        .objHeight (objHeight)
    ) u_spriteLocator (
        .Clk        (Clk),
        .rst        (rst),
        .pixReq     (pixReq),
        .pixX       (pixX),
        .pixY       (pixY),
        .pixAck     (pixAck),
        .isObj      (isObj),
        .objAddress (objAddress),
        .state      (enemyState.locator)
    );

endmodule

//--- test/enemyModel.svh
`ifndef ENEMY_MODEL_SVH
`define ENEMY_MODEL_SVH

// Software copy of the enemy corner, facing and walk step
int  mX;
int  mY;
dirT mDir;
int  mStep;

function automatic void resetModel();
    mX    = startX - objWidth / 2;
    mY    = startY - objHeight / 2;
    mDir  = dirDown;
    mStep = 0;
endfunction

// One move tick toward the player with the horizontal axis first
function automatic void advanceModel(input int px, input int py);
    bit moved;
    moved = 1'b0;
    if (mX < px) begin
        mDir = dirRight;
        if (mX + objWidth < xMax) begin   // Right edge must stay short of xMax
            mX    = mX + 1;
            moved = 1'b1;
        end
    end else if (mX > px) begin
        mDir = dirLeft;
        if (mX > xMin) begin
            mX    = mX - 1;
            moved = 1'b1;
        end
    end else if (mY < py) begin
        mDir = dirDown;
        if (mY + objHeight < yMax) begin
            mY    = mY + 1;
            moved = 1'b1;
        end
    end else if (mY > py) begin
        mDir = dirUp;
        if (mY > yMin) begin
            mY    = mY - 1;
            moved = 1'b1;
        end
    end
    if (moved) begin
        mStep = (mStep + 1) % 4;
    end
endfunction

// Expected sprite address of a pixel or -1 outside the box
function automatic int refAnswer(input int px, input int py);
    int frame;
    if (px < mX || px >= mX + objWidth || py < mY || py >= mY + objHeight) begin
        return -1;
    end
    frame = FRAMES_PER_DIR * int'(mDir);   // Standing frame of this direction
    if (mStep % 2 == 1) begin
        frame = frame + 1 + mStep / 2;
    end
    return (px - mX) + (py - mY) * objWidth + objWidth * objHeight * frame;
endfunction

`endif

//--- test/enemyTb.sv
`timescale 1ns/100ps

module enemyTb import gamePkg::*; ();

    localparam int objWidth    = 26;
    localparam int objHeight   = 26;
    localparam int startX      = 100;
    localparam int startY      = 60;
    localparam int xMin        = 0;
    localparam int xMax        = 319;
    localparam int yMin        = 0;
    localparam int yMax        = 239;
    localparam int tickDivide  = 4;
    localparam int halfFrame   = 8;       // Clocks per frame clock level
    localparam int totalFrames = 1300;    // Upper bound over all tests
    localparam int ackLimit    = 16;

    logic       Clk;
    logic       rst;
    logic       frameClk;
    coordT      playerX;
    coordT      playerY;
    logic       pixReq;
    coordT      pixX;
    coordT      pixY;
    logic       pixAck;
    logic       isObj;
    spriteAddrT objAddress;

    integer seed;
    int     riseCount;
    int     checkCount;
    int     valueErrors;
    int     otherErrors;
    logic   ackSeen;
    int     expAddrQ[$];
    string  expNameQ[$];

    `include "enemyModel.svh"

    enemyTop #(
        .objWidth   (objWidth),
        .objHeight  (objHeight),
        .startX     (startX),
        .startY     (startY),
        .xMin       (xMin),
        .xMax       (xMax),
        .yMin       (yMin),
        .yMax       (yMax),
        .tickDivide (tickDivide)
    ) u_dut (
        .Clk        (Clk),
        .rst        (rst),
        .frameClk   (frameClk),
        .playerX    (playerX),
        .playerY    (playerY),
        .pixReq     (pixReq),
        .pixX       (pixX),
        .pixY       (pixY),
        .pixAck     (pixAck),
        .isObj      (isObj),
        .objAddress (objAddress)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    task automatic setPlayer(input int x, input int y);
        @(posedge Clk);
        playerX <= coordT'(x);
        playerY <= coordT'(y);
    endtask

    // Each rise of the frame clock counts and every fourth one moves the model
    task automatic runFrames(input int count);
        repeat (count) begin
            @(posedge Clk);
            frameClk <= 1'b1;
            riseCount++;
            if (riseCount % tickDivide == 0) begin
                advanceModel(int'(playerX), int'(playerY));
            end
            repeat (halfFrame) @(posedge Clk);
            frameClk <= 1'b0;
            repeat (halfFrame - 1) @(posedge Clk);
        end
    endtask

    task automatic waitAck(input string name, input logic level);
        int cycles;
        cycles = 0;
        do begin
            @(negedge Clk);
            cycles++;
        end while (pixAck !== level && cycles < ackLimit);
        if (pixAck !== level) begin
            $display("Query %s: pixAck did not go %s within %0d cycles",
                     name, level ? "high" : "low", ackLimit);
            otherErrors++;
        end
    endtask

    task automatic issueQuery(input string name, input int x, input int y);
        @(posedge Clk);
        pixX   <= coordT'(x);
        pixY   <= coordT'(y);
        pixReq <= 1'b1;
        expAddrQ.push_back(refAnswer(x, y));   // Model state at issue time
        expNameQ.push_back(name);
        waitAck(name, 1'b1);
    endtask

    task automatic releaseQuery(input string name);
        @(posedge Clk);
        pixReq <= 1'b0;
        waitAck(name, 1'b0);
    endtask

    task automatic doQuery(input string name, input int x, input int y);
        issueQuery(name, x, y);
        releaseQuery(name);
    endtask

    // Compare each answer on the rise of pixAck
    always @(negedge Clk) begin
        int    expAddr;
        string name;
        if (!rst && pixAck && !ackSeen) begin
            if (expAddrQ.size() == 0) begin
                $display("pixAck rose with no query outstanding");
                otherErrors++;
            end else begin
                expAddr = expAddrQ.pop_front();
                name    = expNameQ.pop_front();
                checkCount++;
                assert (isObj === (expAddr >= 0)) else begin
                    $display("ERROR %s isObj expected %0d actual %0d",
                             name, expAddr >= 0, isObj);
                    valueErrors++;
                end
                assert (objAddress === spriteAddrT'((expAddr >= 0) ? expAddr : 0)) else begin
                    $display("ERROR %s objAddress expected %0d actual %0d",
                             name, (expAddr >= 0) ? expAddr : 0, objAddress);
                    valueErrors++;
                end
            end
        end
        ackSeen = pixAck;
    end

    initial begin
        repeat (totalFrames * 2 * halfFrame + 5000) @(posedge Clk);
        $display("Watchdog expired, the tests did not finish in time");
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checkCount, valueErrors, otherErrors + 1);
        $display(">>> FAIL");
        $finish;
    end

    initial begin
        int         x;
        int         y;
        int         hits;
        int         misses;
        int         heldExp;
        rst         = 1'b1;
        frameClk    = 1'b0;
        playerX     = coordT'(startX - objWidth / 2);
        playerY     = coordT'(startY - objHeight / 2);
        pixReq      = 1'b0;
        pixX        = '0;
        pixY        = '0;
        seed        = 32'h562d;
        riseCount   = 0;
        checkCount  = 0;
        valueErrors = 0;
        otherErrors = 0;
        ackSeen     = 1'b0;
        hits        = 0;
        misses      = 0;
        resetModel();
        repeat (2) @(posedge Clk);
        rst <= 1'b0;

        doQuery("reset corner", 87, 47);
        doQuery("reset left of box", 86, 47);

        // Player to the right and level in Y
        setPlayer(200, mY);
        for (int k = 1; k <= 5; k++) begin
            runFrames(tickDivide);
            doQuery($sformatf("right k=%0d corner", k), mX, mY);
            doQuery($sformatf("right k=%0d inside", k), mX + 13, mY + 20);
            doQuery($sformatf("right k=%0d behind", k), mX - 1, mY);
        end

        // Player below and level in X until level on both axes
        setPlayer(mX, mY + 6);
        runFrames(6 * tickDivide);
        doQuery("down corner", mX, mY);
        doQuery("down inside", mX + 4, mY + 9);
        runFrames(2 * tickDivide);
        doQuery("level corner", mX, mY);
        doQuery("level inside", mX + 25, mY + 25);
        doQuery("level above", mX, mY - 1);

        // Player at column 0 is level in X once the enemy reaches xMin
        setPlayer(xMin, mY);
        runFrames((mX - xMin + 2) * tickDivide);
        doQuery("xmin corner", mX, mY);
        doQuery("xmin right edge", mX + objWidth - 1, mY + 3);
        doQuery("xmin past edge", mX + objWidth, mY);
        setPlayer(xMin, yMax);
        runFrames((yMax - objHeight - mY + 3) * tickDivide);   // Blocked ticks at the bottom
        doQuery("bottom corner", mX, mY);
        doQuery("bottom inside", mX + 5, mY + 25);
        doQuery("bottom below", mX, mY + objHeight);

        // Answer held while pixReq stays high
        setPlayer(200, mY);
        heldExp = refAnswer(mX + 2, mY + 2);
        issueQuery("hold", mX + 2, mY + 2);
        for (int f = 0; f < 2 * tickDivide; f++) begin
            runFrames(1);
            @(negedge Clk);
            assert (pixAck === 1'b1) else begin
                $display("pixAck fell while pixReq was held, frame %0d", f);
                otherErrors++;
            end
            assert (isObj === (heldExp >= 0) &&
                    objAddress === spriteAddrT'((heldExp >= 0) ? heldExp : 0)) else begin
                $display("ERROR hold frame %0d expected %0d/%0d actual %0d/%0d",
                         f, heldExp >= 0, (heldExp >= 0) ? heldExp : 0, isObj, objAddress);
                valueErrors++;
            end
        end
        releaseQuery("hold");
        doQuery("after hold corner", mX, mY);

        // Random players with half the pixels near the box
        for (int r = 0; r < 10; r++) begin
            setPlayer($unsigned($random(seed)) % 320, $unsigned($random(seed)) % 240);
            runFrames(2 * tickDivide);
            for (int j = 0; j < 20; j++) begin
                if (j % 2 == 0) begin
                    x = $unsigned($random(seed)) % 320;
                    y = $unsigned($random(seed)) % 240;
                end else begin
                    x = mX - 3 + $unsigned($random(seed)) % 32;
                    y = mY - 3 + $unsigned($random(seed)) % 32;
                end
                x = (x < 0) ? 0 : ((x > xMax) ? xMax : x);   // Stay on the playfield
                y = (y < 0) ? 0 : ((y > yMax) ? yMax : y);
                if (refAnswer(x, y) >= 0) begin
                    hits++;
                end else begin
                    misses++;
                end
                doQuery($sformatf("random %0d.%0d", r, j), x, y);
            end
        end
        assert (hits > 0 && misses > 0) else begin
            $display("Random queries did not reach both in-box and out-of-box pixels");
            otherErrors++;
        end

        repeat (2) @(posedge Clk);
        $display("Checks %0d, value errors %0d, other errors %0d",
                 checkCount, valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+test
hw/gamePkg.sv
hw/enemyStateIf.sv
hw/frameTick.sv
hw/enemyChaser.sv
hw/spriteLocator.sv
hw/enemyTop.sv
test/enemyTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the enemy testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f vlog.f --top-module enemyTb \
    -Mdir "$OBJ" -o enemySim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

"./$OBJ/enemySim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q ">>> FAIL" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q ">>> PASS" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0
